//--- common/decode_pkg.sv
package decode_pkg;

    // ------------------------------------------------
    // Basic types
    // ------------------------------------------------
    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  exc_code_t;

    localparam reg_addr_t REG_RA  = 5'd1;   // BL link register
    localparam exc_code_t EXC_INE = 6'h0D;  // Instruction not exist

    // ------------------------------------------------
    // ALU operation and result class
    // ------------------------------------------------
    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_ADD,            // ADD.W and ADDI.W
        ALU_SUB,
        ALU_SLT,            // SLT and SLTI
        ALU_SLTU,           // SLTU and SLTUI
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_B,
        ALU_BL,
        ALU_JIRL,
        ALU_LD_W,
        ALU_ST_W
    } alu_op_t;

    typedef enum logic [2:0] {
        ALU_SEL_NOP         = 3'd0,
        ALU_SEL_ARITH       = 3'd1,
        ALU_SEL_LOGIC       = 3'd2,
        ALU_SEL_JUMP_BRANCH = 3'd3,
        ALU_SEL_LOAD_STORE  = 3'd4
    } alu_sel_t;

    // ------------------------------------------------
    // Opcodes, 2RI16 format, inst[31:26]
    // ------------------------------------------------
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;
    localparam logic [5:0] OPC_BLT  = 6'h18;
    localparam logic [5:0] OPC_BGE  = 6'h19;
    localparam logic [5:0] OPC_BLTU = 6'h1A;
    localparam logic [5:0] OPC_BGEU = 6'h1B;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_SLTUI  = 10'h009;
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC_ANDI   = 10'h00D;
    localparam logic [9:0] OPC_ORI    = 10'h00E;
    localparam logic [9:0] OPC_XORI   = 10'h00F;
    localparam logic [9:0] OPC_LD_W   = 10'h0A2;
    localparam logic [9:0] OPC_ST_W   = 10'h0A6;

    // 3R format, inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_NOR   = 17'h00028;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002A;
    localparam logic [16:0] OPC_XOR   = 17'h0002B;

    // ------------------------------------------------
    // Dispatch record
    // ------------------------------------------------
    typedef struct packed {
        bus32_t          pc;
        bus32_t          inst;
        logic            inst_valid;        // Claimed by a decoder
        logic [1:0]      reg_read_en;       // Index 0 is port 0
        reg_addr_t [1:0] reg_read_addr;
        logic            reg_write_en;
        reg_addr_t       reg_write_addr;
        alu_op_t         aluop;
        alu_sel_t        alusel;
        bus32_t          imm;
        logic            is_exception;
        exc_code_t       exception_cause;
    } id_dispatch_t;

endpackage

//--- hw/decoder/decoder_2ri16.sv
module decoder_2ri16 (
    input  decode_pkg::bus32_t       pc_i,
    input  decode_pkg::bus32_t       inst_i,
    output decode_pkg::id_dispatch_t id_o
);

    import decode_pkg::*;

    logic [5:0]  opcode;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [15:0] offs16;
    logic [25:0] offs26;
    bus32_t      imm_offs16;
    bus32_t      imm_offs26;

    assign opcode = inst_i[31:26];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];
    assign offs16 = inst_i[25:10];
    assign offs26 = {inst_i[9:0], inst_i[25:10]};   // High part sits in the rd/rj slots

    assign imm_offs16 = {{14{offs16[15]}}, offs16, 2'b00};
    assign imm_offs26 = {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        id_o      = '0;
        id_o.pc   = pc_i;
        id_o.inst = inst_i;

        case (opcode)
            OPC_BEQ:  id_o.aluop = ALU_BEQ;
            OPC_BNE:  id_o.aluop = ALU_BNE;
            OPC_BLT:  id_o.aluop = ALU_BLT;
            OPC_BGE:  id_o.aluop = ALU_BGE;
            OPC_BLTU: id_o.aluop = ALU_BLTU;
            OPC_BGEU: id_o.aluop = ALU_BGEU;
            OPC_B:    id_o.aluop = ALU_B;
            OPC_BL:   id_o.aluop = ALU_BL;
            OPC_JIRL: id_o.aluop = ALU_JIRL;
            default:  id_o.aluop = ALU_NOP;
        endcase

        case (id_o.aluop)
            ALU_NOP: begin
            end
            ALU_B: begin
                id_o.imm = imm_offs26;
            end
            ALU_BL: begin
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = REG_RA;
                id_o.imm            = imm_offs26;
            end
            ALU_JIRL: begin
                id_o.reg_read_en[0]   = 1'b1;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_write_en     = 1'b1;
                id_o.reg_write_addr   = rd;
                id_o.imm              = imm_offs16;
            end
            default: begin                                   // Conditional branches
                id_o.reg_read_en      = 2'b11;
                id_o.reg_read_addr[0] = rj;
                id_o.reg_read_addr[1] = rd;                  // rd is a source here
                id_o.imm              = imm_offs16;
            end
        endcase

        if (id_o.aluop != ALU_NOP) begin
            id_o.inst_valid = 1'b1;
            id_o.alusel     = ALU_SEL_JUMP_BRANCH;
        end
    end

    // Unconditional jump has no register operand
    always_comb begin
        if (opcode == OPC_B) begin
            assert final (id_o.reg_read_en == 2'b00)
                else $error("B decoded with a register read enabled");
        end
    end

endmodule

//--- hw/decoder/decoder_2ri12.sv
module decoder_2ri12 (
    input  decode_pkg::bus32_t       pc_i,
    input  decode_pkg::bus32_t       inst_i,
    output decode_pkg::id_dispatch_t id_o
);

    import decode_pkg::*;

    logic [9:0]  opcode;
    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [11:0] si12;
    bus32_t      imm_sext;
    bus32_t      imm_zext;

    assign opcode = inst_i[31:22];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];
    assign si12   = inst_i[21:10];

    assign imm_sext = {{20{si12[11]}}, si12};
    assign imm_zext = {20'b0, si12};       // Bitwise immediates

    always_comb begin
        id_o      = '0;
        id_o.pc   = pc_i;
        id_o.inst = inst_i;

        case (opcode)
            OPC_SLTI: begin
                id_o.aluop  = ALU_SLT;
                id_o.alusel = ALU_SEL_ARITH;
                id_o.imm    = imm_sext;
            end
            OPC_SLTUI: begin
                id_o.aluop  = ALU_SLTU;
                id_o.alusel = ALU_SEL_ARITH;
                id_o.imm    = imm_sext;
            end
            OPC_ADDI_W: begin
                id_o.aluop  = ALU_ADD;
                id_o.alusel = ALU_SEL_ARITH;
                id_o.imm    = imm_sext;
            end
            OPC_ANDI: begin
                id_o.aluop  = ALU_AND;
                id_o.alusel = ALU_SEL_LOGIC;
                id_o.imm    = imm_zext;
            end
            OPC_ORI: begin
                id_o.aluop  = ALU_OR;
                id_o.alusel = ALU_SEL_LOGIC;
                id_o.imm    = imm_zext;
            end
            OPC_XORI: begin
                id_o.aluop  = ALU_XOR;
                id_o.alusel = ALU_SEL_LOGIC;
                id_o.imm    = imm_zext;
            end
            OPC_LD_W: begin
                id_o.aluop  = ALU_LD_W;
                id_o.alusel = ALU_SEL_LOAD_STORE;
                id_o.imm    = imm_sext;       // Address offset
            end
            OPC_ST_W: begin
                id_o.aluop  = ALU_ST_W;
                id_o.alusel = ALU_SEL_LOAD_STORE;
                id_o.imm    = imm_sext;
            end
            default: begin
            end
        endcase

        if (id_o.alusel != ALU_SEL_NOP) begin
            id_o.inst_valid       = 1'b1;
            id_o.reg_read_en[0]   = 1'b1;      // Base or source is always rj
            id_o.reg_read_addr[0] = rj;
            if (id_o.aluop == ALU_ST_W) begin
                id_o.reg_read_en[1]   = 1'b1;  // Store data
                id_o.reg_read_addr[1] = rd;
            end else begin
                id_o.reg_write_en   = 1'b1;
                id_o.reg_write_addr = rd;
            end
        end
    end

endmodule

//--- hw/decoder/decoder_3r.sv
module decoder_3r (
    input  decode_pkg::bus32_t       pc_i,
    input  decode_pkg::bus32_t       inst_i,
    output decode_pkg::id_dispatch_t id_o
);

    import decode_pkg::*;

    logic [16:0] opcode;
    reg_addr_t   rk;
    reg_addr_t   rj;
    reg_addr_t   rd;

    assign opcode = inst_i[31:15];
    assign rk     = inst_i[14:10];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];

    always_comb begin
        id_o      = '0;                 // imm stays zero for this format
        id_o.pc   = pc_i;
        id_o.inst = inst_i;

        case (opcode)
            OPC_ADD_W: begin
                id_o.aluop  = ALU_ADD;
                id_o.alusel = ALU_SEL_ARITH;
            end
            OPC_SUB_W: begin
                id_o.aluop  = ALU_SUB;
                id_o.alusel = ALU_SEL_ARITH;
            end
            OPC_SLT: begin
                id_o.aluop  = ALU_SLT;
                id_o.alusel = ALU_SEL_ARITH;
            end
            OPC_SLTU: begin
                id_o.aluop  = ALU_SLTU;
                id_o.alusel = ALU_SEL_ARITH;
            end
            OPC_NOR: begin
                id_o.aluop  = ALU_NOR;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            OPC_AND: begin
                id_o.aluop  = ALU_AND;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            OPC_OR: begin
                id_o.aluop  = ALU_OR;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            OPC_XOR: begin
                id_o.aluop  = ALU_XOR;
                id_o.alusel = ALU_SEL_LOGIC;
            end
            default: begin
            end
        endcase

        if (id_o.alusel != ALU_SEL_NOP) begin
            id_o.inst_valid       = 1'b1;
            id_o.reg_read_en      = 2'b11;
            id_o.reg_read_addr[0] = rj;
            id_o.reg_read_addr[1] = rk;
            id_o.reg_write_en     = 1'b1;
            id_o.reg_write_addr   = rd;
        end
    end

endmodule

//--- hw/decoder/id_select.sv
module id_select (
    input  logic                     clk_i,
    input  decode_pkg::id_dispatch_t rec_2ri16_i,
    input  decode_pkg::id_dispatch_t rec_2ri12_i,
    input  decode_pkg::id_dispatch_t rec_3r_i,
    output decode_pkg::id_dispatch_t id_o
);

    import decode_pkg::*;

    logic [2:0] claim;

    assign claim = {rec_2ri16_i.inst_valid, rec_2ri12_i.inst_valid, rec_3r_i.inst_valid};

    always_comb begin
        if (rec_2ri16_i.inst_valid) begin
            id_o = rec_2ri16_i;
        end else if (rec_2ri12_i.inst_valid) begin
            id_o = rec_2ri12_i;
        end else if (rec_3r_i.inst_valid) begin
            id_o = rec_3r_i;
        end else begin
            // Nobody knows this encoding
            id_o                 = '0;
            id_o.pc              = rec_3r_i.pc;     // Same pc/inst on every record
            id_o.inst            = rec_3r_i.inst;
            id_o.aluop           = ALU_NOP;
            id_o.alusel          = ALU_SEL_NOP;
            id_o.is_exception    = 1'b1;
            id_o.exception_cause = EXC_INE;
        end
    end

    // ------------------------------------------------
    // Format decoders must not overlap
    // ------------------------------------------------
    a_single_claim : assert property (@(posedge clk_i) $onehot0(claim))
        else $error("More than one decoder claimed inst %h", rec_3r_i.inst);

endmodule

//--- hw/id_stage.sv
module id_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     valid_i,
    input  decode_pkg::bus32_t       pc_i,
    input  decode_pkg::bus32_t       inst_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    output logic                     valid_o,
    output decode_pkg::id_dispatch_t id_o
);

    import decode_pkg::*;

    id_dispatch_t rec_2ri16;
    id_dispatch_t rec_2ri12;
    id_dispatch_t rec_3r;
    id_dispatch_t dec_rec;

    logic         valid_q;
    id_dispatch_t id_q;

    // ------------------------------------------------
    // Format decoders, all looking at the same word
    // ------------------------------------------------
    decoder_2ri16 u_dec_2ri16 (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_2ri16)
    );

    decoder_2ri12 u_dec_2ri12 (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_2ri12)
    );

    decoder_3r u_dec_3r (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .id_o   (rec_3r)
    );

    id_select u_select (
        .clk_i       (clk_i),
        .rec_2ri16_i (rec_2ri16),
        .rec_2ri12_i (rec_2ri12),
        .rec_3r_i    (rec_3r),
        .id_o        (dec_rec)
    );

    // ------------------------------------------------
    // Decode to dispatch register
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            id_q    <= '0;
        end else if (flush_i) begin
            valid_q <= 1'b0;                 // Wins over stall
        end else if (!stall_i) begin
            valid_q <= valid_i;
            if (valid_i) begin
                id_q <= dec_rec;
            end
        end
    end

    assign valid_o = valid_q;
    assign id_o    = id_q;

    a_stall_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i && !flush_i |=> $stable(id_o) && $stable(valid_o))
        else $error("Dispatch record changed during stall");

endmodule

//--- dv/id_stage_tb.sv
module id_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    localparam int     CLK_PERIOD = 20;
    localparam int     NUM_TESTS  = 6;
    localparam bus32_t PC_BASE    = 32'h1c00_0000;

    // Opcode tables with the expected ALU operation and result class
    localparam logic [5:0] BR_OPS [9] = '{OPC_BEQ, OPC_BNE, OPC_BLT, OPC_BGE, OPC_BLTU,
                                           OPC_BGEU, OPC_B, OPC_BL, OPC_JIRL};
    localparam alu_op_t    BR_ALU [9] = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU,
                                           ALU_BGEU, ALU_B, ALU_BL, ALU_JIRL};
    localparam logic [9:0] IMM_OPS [8] = '{OPC_SLTI, OPC_SLTUI, OPC_ADDI_W, OPC_ANDI,
                                            OPC_ORI, OPC_XORI, OPC_LD_W, OPC_ST_W};
    localparam alu_op_t    IMM_ALU [8] = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND,
                                            ALU_OR, ALU_XOR, ALU_LD_W, ALU_ST_W};
    localparam alu_sel_t   IMM_SEL [8] = '{ALU_SEL_ARITH, ALU_SEL_ARITH, ALU_SEL_ARITH,
                                            ALU_SEL_LOGIC, ALU_SEL_LOGIC, ALU_SEL_LOGIC,
                                            ALU_SEL_LOAD_STORE, ALU_SEL_LOAD_STORE};
    localparam logic [16:0] REG_OPS [8] = '{OPC_ADD_W, OPC_SUB_W, OPC_SLT, OPC_SLTU,
                                             OPC_NOR, OPC_AND, OPC_OR, OPC_XOR};
    localparam alu_op_t    REG_ALU [8] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
                                            ALU_NOR, ALU_AND, ALU_OR, ALU_XOR};

    logic         clk_i;
    logic         rst_n_i;
    logic         valid_i;
    bus32_t       pc_i;
    bus32_t       inst_i;
    logic         stall_i;
    logic         flush_i;
    logic         valid_o;
    id_dispatch_t id_o;

    int errors = 0;
    int checks = 0;

    id_stage dut_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .pc_i    (pc_i),
        .inst_i  (inst_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_o (valid_o),
        .id_o    (id_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic bus32_t branch_word(logic [5:0] op, logic [15:0] offs,
                                           reg_addr_t rj, reg_addr_t rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic bus32_t jump_word(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};         // High offset bits go low
    endfunction

    function automatic bus32_t imm12_word(logic [9:0] op, logic [11:0] si12,
                                          reg_addr_t rj, reg_addr_t rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic bus32_t reg3_word(logic [16:0] op, reg_addr_t rk,
                                         reg_addr_t rj, reg_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    // Expected dispatch record, built from the ISA field rules
    function automatic id_dispatch_t expect_record(bus32_t pc, bus32_t inst);
        id_dispatch_t       r;
        int                 fmt;
        logic signed [25:0] o26;
        bus32_t             b16;
        bus32_t             b26;
        bus32_t             sx12;
        bus32_t             zx12;
        o26    = {inst[9:0], inst[25:10]};
        b16    = 32'($signed(inst[25:10])) << 2;
        b26    = 32'(o26) << 2;
        sx12   = 32'($signed(inst[21:10]));
        zx12   = 32'(inst[21:10]);
        fmt    = 0;
        r      = '0;
        r.pc   = pc;
        r.inst = inst;
        for (int k = 0; k < 9; k++) begin
            if (inst[31:26] == BR_OPS[4'(k)]) begin
                r.aluop  = BR_ALU[4'(k)];
                r.alusel = ALU_SEL_JUMP_BRANCH;
                fmt      = 1;
            end
        end
        for (int k = 0; k < 8; k++) begin
            if (inst[31:22] == IMM_OPS[3'(k)]) begin
                r.aluop  = IMM_ALU[3'(k)];
                r.alusel = IMM_SEL[3'(k)];
                fmt      = 2;
            end
            if (inst[31:15] == REG_OPS[3'(k)]) begin
                r.aluop  = REG_ALU[3'(k)];
                r.alusel = (k < 4) ? ALU_SEL_ARITH : ALU_SEL_LOGIC;
                fmt      = 3;
            end
        end
        case (fmt)
            1: begin
                if (r.aluop == ALU_B || r.aluop == ALU_BL) begin
                    r.imm = b26;
                end else begin
                    r.imm = b16;
                end
                if (r.aluop == ALU_BL) begin
                    r.reg_write_en   = 1'b1;
                    r.reg_write_addr = 5'd1;
                end else if (r.aluop == ALU_JIRL) begin
                    r.reg_read_en[0]   = 1'b1;
                    r.reg_read_addr[0] = inst[9:5];
                    r.reg_write_en     = 1'b1;
                    r.reg_write_addr   = inst[4:0];
                end else if (r.aluop != ALU_B) begin
                    r.reg_read_en      = 2'b11;
                    r.reg_read_addr[0] = inst[9:5];
                    r.reg_read_addr[1] = inst[4:0];
                end
            end
            2: begin
                r.reg_read_en[0]   = 1'b1;
                r.reg_read_addr[0] = inst[9:5];
                r.imm = (inst[31:22] inside {OPC_ANDI, OPC_ORI, OPC_XORI}) ? zx12 : sx12;
                if (r.aluop == ALU_ST_W) begin
                    r.reg_read_en[1]   = 1'b1;
                    r.reg_read_addr[1] = inst[4:0];
                end else begin
                    r.reg_write_en   = 1'b1;
                    r.reg_write_addr = inst[4:0];
                end
            end
            3: begin
                r.reg_read_en      = 2'b11;
                r.reg_read_addr[0] = inst[9:5];
                r.reg_read_addr[1] = inst[14:10];
                r.reg_write_en     = 1'b1;
                r.reg_write_addr   = inst[4:0];
            end
            default: begin
                r.is_exception    = 1'b1;
                r.exception_cause = EXC_INE;
            end
        endcase
        r.inst_valid = (fmt != 0);
        return r;
    endfunction

    function automatic bus32_t random_inst();
        logic [3:0] kb;
        logic [2:0] k8;
        bus32_t     w;
        kb = 4'($urandom_range(0, 8));
        k8 = 3'($urandom());
        case ($urandom_range(0, 2))
            0: begin
                if (BR_OPS[kb] == OPC_B || BR_OPS[kb] == OPC_BL) begin
                    w = jump_word(BR_OPS[kb], 26'($urandom()));
                end else begin
                    w = branch_word(BR_OPS[kb], 16'($urandom()), 5'($urandom()),
                                    5'($urandom()));
                end
            end
            1: w = imm12_word(IMM_OPS[k8], 12'($urandom()), 5'($urandom()), 5'($urandom()));
            default: w = reg3_word(REG_OPS[k8], 5'($urandom()), 5'($urandom()),
                                   5'($urandom()));
        endcase
        return w;
    endfunction

    // --------------------------------------------------
    // Drive and check helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive_inst(bus32_t pc, bus32_t inst);
        valid_i = 1'b1;
        pc_i    = pc;
        inst_i  = inst;
    endtask

    task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp === act)
            else begin
                $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
                errors++;
            end
    endtask

    task automatic check_fields(id_dispatch_t exp);
        check_field("id_o.pc", exp.pc, id_o.pc);
        check_field("id_o.inst", exp.inst, id_o.inst);
        check_field("id_o.inst_valid", 32'(exp.inst_valid), 32'(id_o.inst_valid));
        check_field("id_o.reg_read_en", 32'(exp.reg_read_en), 32'(id_o.reg_read_en));
        check_field("id_o.reg_read_addr", 32'(exp.reg_read_addr),
                    32'(id_o.reg_read_addr));
        check_field("id_o.reg_write_en", 32'(exp.reg_write_en), 32'(id_o.reg_write_en));
        check_field("id_o.reg_write_addr", 32'(exp.reg_write_addr),
                    32'(id_o.reg_write_addr));
        check_field("id_o.aluop", 32'(exp.aluop), 32'(id_o.aluop));
        check_field("id_o.alusel", 32'(exp.alusel), 32'(id_o.alusel));
        check_field("id_o.imm", exp.imm, id_o.imm);
        check_field("id_o.is_exception", 32'(exp.is_exception), 32'(id_o.is_exception));
        check_field("id_o.exception_cause", 32'(exp.exception_cause),
                    32'(id_o.exception_cause));
    endtask

    task automatic check_record(logic exp_valid, id_dispatch_t exp);
        check_field("valid_o", 32'(exp_valid), 32'(valid_o));
        if (exp_valid) begin
            check_fields(exp);
        end
    endtask

    task automatic apply_and_check(bus32_t pc, bus32_t inst);
        drive_inst(pc, inst);
        next_cycle();
        check_record(1'b1, expect_record(pc, inst));
    endtask

    task automatic report_test(string name, int err_start);
        valid_i = 1'b0;
        $display("%-20s done, %0d errors", name, errors - err_start);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic reset_values();
        int err_start;
        err_start = errors;
        next_cycle();
        check_field("valid_o", 32'(1'b0), 32'(valid_o));
        check_fields('0);
        report_test("reset_values", err_start);
    endtask

    task automatic branch_decode();
        int          err_start;
        logic [15:0] offs16;
        logic [25:0] offs26;
        bus32_t      pc;
        err_start = errors;
        for (int k = 0; k < 9; k++) begin
            for (int n = 0; n < 3; n++) begin
                offs16 = 16'($urandom());
                offs26 = 26'($urandom());
                if (n == 0) begin
                    offs16[15] = 1'b1;                        // Backward targets
                    offs26[25] = 1'b1;
                end
                pc = PC_BASE + 32'(k * 16 + n * 4);
                if (BR_OPS[4'(k)] == OPC_B || BR_OPS[4'(k)] == OPC_BL) begin
                    apply_and_check(pc, jump_word(BR_OPS[4'(k)], offs26));
                end else begin
                    apply_and_check(pc, branch_word(BR_OPS[4'(k)], offs16, 5'($urandom()),
                                                    5'($urandom())));
                end
            end
        end
        report_test("branch_decode", err_start);
    endtask

    task automatic imm_and_reg_decode();
        int          err_start;
        logic [11:0] si12;
        err_start = errors;
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 3; n++) begin
                si12 = 12'($urandom());
                if (n == 0) begin
                    si12[11] = 1'b1;                          // Sign bit set
                end else if (n == 1) begin
                    si12[11] = 1'b0;
                end
                apply_and_check(PC_BASE + 32'(k * 16 + n * 4),
                                imm12_word(IMM_OPS[3'(k)], si12, 5'($urandom()),
                                           5'($urandom())));
                apply_and_check(PC_BASE + 32'h400 + 32'(k * 16 + n * 4),
                                reg3_word(REG_OPS[3'(k)], 5'($urandom()), 5'($urandom()),
                                          5'($urandom())));
            end
        end
        report_test("imm_and_reg_decode", err_start);
    endtask

    task automatic unknown_inst();
        int err_start;
        err_start = errors;
        apply_and_check(PC_BASE + 32'h10, 32'h0000_0000);
        apply_and_check(PC_BASE + 32'h14, 32'hffff_ffff);
        apply_and_check(PC_BASE + 32'h18, {17'h00021, 15'($urandom())});   // 3R gap
        apply_and_check(PC_BASE + 32'h1c, {10'h00b, 22'($urandom())});     // 2RI12 gap
        apply_and_check(PC_BASE + 32'h20, {6'h1c, 26'($urandom())});       // Past BGEU
        report_test("unknown_inst", err_start);
    endtask

    task automatic stall_and_flush();
        int     err_start;
        bus32_t inst_a;
        bus32_t inst_b;
        err_start = errors;
        inst_a = reg3_word(OPC_ADD_W, 5'd3, 5'd2, 5'd1);
        inst_b = imm12_word(OPC_ORI, 12'hf0f, 5'd4, 5'd5);
        apply_and_check(PC_BASE, inst_a);
        stall_i = 1'b1;
        for (int i = 0; i < 4; i++) begin
            drive_inst(PC_BASE + 32'h40 + 32'(i * 4), random_inst());
            next_cycle();
            check_record(1'b1, expect_record(PC_BASE, inst_a));
        end
        drive_inst(PC_BASE + 32'h4, inst_b);
        stall_i = 1'b0;
        next_cycle();
        check_record(1'b1, expect_record(PC_BASE + 32'h4, inst_b));
        stall_i = 1'b1;
        drive_inst(PC_BASE + 32'h8, inst_a);
        next_cycle();
        check_record(1'b1, expect_record(PC_BASE + 32'h4, inst_b));
        flush_i = 1'b1;                                       // Flush under stall
        next_cycle();
        check_field("valid_o", 32'(1'b0), 32'(valid_o));
        flush_i = 1'b0;
        stall_i = 1'b0;
        valid_i = 1'b0;
        next_cycle();
        check_field("valid_o", 32'(1'b0), 32'(valid_o));
        report_test("stall_and_flush", err_start);
    endtask

    task automatic back_to_back();
        int           err_start;
        bus32_t       pc;
        bus32_t       inst;
        id_dispatch_t pending[$];
        err_start = errors;
        for (int i = 0; i < 20; i++) begin
            pc   = PC_BASE + 32'h800 + 32'(i * 4);
            inst = random_inst();
            drive_inst(pc, inst);
            if (i > 0) begin
                check_record(1'b1, pending.pop_front());      // Output still one behind
            end
            pending.push_back(expect_record(pc, inst));
            next_cycle();
        end
        check_record(1'b1, pending.pop_front());
        report_test("back_to_back", err_start);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(29870));
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        pc_i    = '0;
        inst_i  = '0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        repeat (2) next_cycle();
        rst_n_i = 1'b1;

        reset_values();
        branch_decode();
        imm_and_reg_decode();
        unknown_inst();
        stall_and_flush();
        back_to_back();

        $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb.f
common/decode_pkg.sv
hw/decoder/decoder_2ri16.sv
hw/decoder/decoder_2ri12.sv
hw/decoder/decoder_3r.sv
hw/decoder/id_select.sv
hw/id_stage.sv
dv/id_stage_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = id_stage_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
